/* src/dmem_bus_pkg.sv */
// CPU-side and Wishbone-side definitions for the data memory block
// Fixed at RV32, little-endian byte lanes, queue depth a power of two
`default_nettype none

package dmem_bus_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  // Address and data width
  localparam int XLEN         = 32;

  // Byte lanes per word and the offset bits that pick a lane
  localparam int SEL_W        = XLEN / 8;
  localparam int BYTE_OFS_W   = $clog2(SEL_W);

  // Request queue
  localparam int MEMBUF_DEPTH = 2;
  localparam int MEMBUF_PTR_W = $clog2(MEMBUF_DEPTH);
  localparam int MEMBUF_CNT_W = $clog2(MEMBUF_DEPTH + 1);

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [XLEN-1:0]       xword_t;
  typedef logic [SEL_W-1:0]      wb_sel_t;
  typedef logic [BYTE_OFS_W-1:0] byte_ofs_t;

  // Access size, same encoding as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    SZ_BYTE = 2'b00,
    SZ_HALF = 2'b01,
    SZ_WORD = 2'b10
  } mem_size_e;

  // One CPU request as held in the queue
  typedef struct packed {
    xword_t    adr;
    mem_size_e size;
    logic      we;
    xword_t    d;
  } mem_req_t;

  // Bus master states
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    BUS  = 2'b01,
    RESP = 2'b10
  } wb_state_e;

endpackage : dmem_bus_pkg

`default_nettype wire

/* src/dmem_pma_pkg.sv */
// Physical memory attribute definitions
// Regions are base/mask pairs, lower index wins where regions overlap
`default_nettype none

package dmem_pma_pkg;

  import dmem_bus_pkg::*;

  ////////////////////////////////////////////////////////////
  // Region table
  ////////////////////////////////////////////////////////////

  // Number of attribute regions checked in parallel
  localparam int PMA_CNT = 4;

  // Static configuration of one region
  // Mask has ones on the address bits that are compared
  typedef struct packed {
    xword_t base;
    xword_t mask;
    logic   en;
    logic   rd;
    logic   wr;
  } pma_region_t;

  // Result of one region check
  typedef struct packed {
    logic match;
    // Only meaningful with match set
    logic allowed;
  } pma_hit_t;

endpackage : dmem_pma_pkg

`default_nettype wire

/* src/dmem_membuf.sv */
// Request queue between CPU and bus master, depth a power of two
// Pushes while full are ignored, the CPU must watch rdy_o
`default_nettype none

module dmem_membuf
  import dmem_bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  // Write side, from the CPU
  input  logic     push_i,
  input  mem_req_t req_i,

  // Read side, to checks and bus master
  input  logic     pop_i,
  output mem_req_t head_o,
  output logic     head_vld_o,
  output logic     rdy_o
);

  ////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////

  mem_req_t                  buf_q [MEMBUF_DEPTH];
  logic [MEMBUF_PTR_W-1:0]   wr_ptr_q;
  logic [MEMBUF_PTR_W-1:0]   rd_ptr_q;
  logic [MEMBUF_CNT_W-1:0]   cnt_q;

  logic                      push_ok;
  logic                      pop_ok;

  // Qualified strobes
  assign push_ok    = push_i & rdy_o;
  assign pop_ok     = pop_i & head_vld_o;

  // Status
  assign rdy_o      = (cnt_q != MEMBUF_CNT_W'(MEMBUF_DEPTH));
  assign head_vld_o = (cnt_q != '0);

  // Head is visible the cycle after the push
  assign head_o     = buf_q[rd_ptr_q];

  // Entry write, payload only
  always_ff @(posedge clk_i)
  begin
    if (push_ok)
    begin
      buf_q[wr_ptr_q] <= req_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointer and count update
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end
    else
    begin
      // Pointers wrap on their own width
      if (push_ok)
      begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_ok)
      begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves count unchanged
      case ({push_ok, pop_ok})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule : dmem_membuf

`default_nettype wire

/* src/dmem_pma_region.sv */
// Attribute check of the queue head against one region
// Purely combinational, head validity is handled by the resolver
`default_nettype none

module dmem_pma_region
  import dmem_bus_pkg::*;
  import dmem_pma_pkg::*;
(
  // Region configuration
  input  pma_region_t cfg_i,

  // Access under test
  input  mem_req_t    head_i,

  // Match and permission
  output pma_hit_t    hit_o
);

  ////////////////////////////////////////////////////////////
  // Address match
  ////////////////////////////////////////////////////////////

  xword_t adr_masked;
  xword_t base_masked;
  logic   match;
  logic   granted;

  // Compare only the bits selected by the mask
  assign adr_masked  = head_i.adr & cfg_i.mask;
  assign base_masked = cfg_i.base & cfg_i.mask;

  // Disabled regions never match
  assign match       = cfg_i.en & (adr_masked == base_masked);

  ////////////////////////////////////////////////////////////
  // Permission
  ////////////////////////////////////////////////////////////

  // Stores need wr, loads need rd
  assign granted     = head_i.we ? cfg_i.wr : cfg_i.rd;

  assign hit_o.match   = match;
  assign hit_o.allowed = match & granted;

endmodule : dmem_pma_region

`default_nettype wire

/* src/dmem_pma_resolve.sv */
// Merges region results and the alignment check into one verdict
// Lowest-index matching region decides, no match is a deny
`default_nettype none

module dmem_pma_resolve
  import dmem_bus_pkg::*;
  import dmem_pma_pkg::*;
(
  // Queue head
  input  mem_req_t head_i,
  input  logic     head_vld_i,

  // One result per region
  input  pma_hit_t hits_i [PMA_CNT],

  // Verdict, go and deny never both high
  output logic     go_o,
  output logic     deny_o,
  output logic     misaligned_o
);

  logic      misaligned;
  logic      found;
  logic      allowed;
  byte_ofs_t ofs;

  assign ofs = head_i.adr[BYTE_OFS_W-1:0];

  ////////////////////////////////////////////////////////////
  // Alignment
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (head_i.size)
      SZ_BYTE: misaligned = 1'b0;
      SZ_HALF: misaligned = ofs[0];
      default: misaligned = |ofs;
    endcase
  end

  // Priority pick, first match from index 0 upward
  always_comb
  begin
    found   = 1'b0;
    allowed = 1'b0;
    for (int i = 0; i < PMA_CNT; i++)
    begin
      if (hits_i[i].match && !found)
      begin
        found   = 1'b1;
        allowed = hits_i[i].allowed;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Verdict
  ////////////////////////////////////////////////////////////

  // Misalignment overrides any region grant
  assign misaligned_o = head_vld_i & misaligned;
  assign go_o         = head_vld_i & ~misaligned & found & allowed;
  assign deny_o       = head_vld_i & (misaligned | ~(found & allowed));

endmodule : dmem_pma_resolve

`default_nettype wire

/* src/dmem_wb_ctrl.sv */
// Wishbone classic master, one single access per request, no bursts
// Head must stay stable until pop_o, loads return zero-extended data
`default_nettype none

module dmem_wb_ctrl
  import dmem_bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  // Queue head and verdict
  input  mem_req_t head_i,
  input  logic     go_i,
  input  logic     deny_i,
  input  logic     misaligned_i,
  output logic     pop_o,

  // CPU response
  output logic     mem_ack_o,
  output logic     mem_err_o,
  output logic     mem_misaligned_o,
  output xword_t   mem_q_o,

  // Wishbone master
  output logic     wb_cyc_o,
  output logic     wb_stb_o,
  output logic     wb_we_o,
  output xword_t   wb_adr_o,
  output wb_sel_t  wb_sel_o,
  output xword_t   wb_dat_o,
  input  xword_t   wb_dat_i,
  input  logic     wb_ack_i,
  input  logic     wb_err_i
);

  wb_state_e state_q;
  logic      cyc_q;
  logic      resp_err_q;
  logic      resp_mis_q;

  byte_ofs_t ofs;
  wb_sel_t   sel_d;
  xword_t    dat_d;
  xword_t    rd_shift;
  xword_t    rd_ext;

  assign ofs = head_i.adr[BYTE_OFS_W-1:0];

  ////////////////////////////////////////////////////////////
  // Lane steering
  ////////////////////////////////////////////////////////////

  // Write data replicated, slave picks lanes by sel
  always_comb
  begin
    case (head_i.size)
      SZ_BYTE:
      begin
        sel_d = wb_sel_t'(4'b0001) << ofs;
        dat_d = {4{head_i.d[7:0]}};
      end
      SZ_HALF:
      begin
        // Lane pair, bit 0 of offset ignored
        sel_d = wb_sel_t'(4'b0011) << {ofs[1], 1'b0};
        dat_d = {2{head_i.d[15:0]}};
      end
      default:
      begin
        sel_d = '1;
        dat_d = head_i.d;
      end
    endcase
  end

  // Read data down to bit 0, then zero-extend
  assign rd_shift = wb_dat_i >> {ofs, 3'b000};

  always_comb
  begin
    case (head_i.size)
      SZ_BYTE: rd_ext = xword_t'(rd_shift[7:0]);
      SZ_HALF: rd_ext = xword_t'(rd_shift[15:0]);
      default: rd_ext = rd_shift;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q    <= IDLE;
      cyc_q      <= 1'b0;
      resp_err_q <= 1'b0;
      resp_mis_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        IDLE:
        begin
          if (go_i)
          begin
            state_q <= BUS;
            cyc_q   <= 1'b1;
          end
          else if (deny_i)
          begin
            // Answered locally, bus untouched
            state_q    <= RESP;
            resp_err_q <= 1'b1;
            resp_mis_q <= misaligned_i;
          end
        end
        BUS:
        begin
          // Slave error wins over ack
          if (wb_err_i || wb_ack_i)
          begin
            state_q    <= RESP;
            cyc_q      <= 1'b0;
            resp_err_q <= wb_err_i;
            resp_mis_q <= 1'b0;
          end
        end
        RESP:
        begin
          state_q    <= IDLE;
          resp_err_q <= 1'b0;
          resp_mis_q <= 1'b0;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Bus payload captured at cycle start, read data at ack
  always_ff @(posedge clk_i)
  begin
    if (state_q == IDLE && go_i)
    begin
      wb_adr_o <= {head_i.adr[XLEN-1:BYTE_OFS_W], {BYTE_OFS_W{1'b0}}};
      wb_sel_o <= sel_d;
      wb_dat_o <= dat_d;
      wb_we_o  <= head_i.we;
    end
    if (state_q == BUS && wb_ack_i && !head_i.we)
    begin
      mem_q_o <= rd_ext;
    end
  end

  // Single access, strobe follows cycle
  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;

  // One response cycle, queue entry retired with it
  assign pop_o            = (state_q == RESP);
  assign mem_ack_o        = pop_o & ~resp_err_q;
  assign mem_err_o        = pop_o & resp_err_q;
  assign mem_misaligned_o = mem_err_o & resp_mis_q;

endmodule : dmem_wb_ctrl

`default_nettype wire

/* src/dmem_ctrl.sv */
// Data memory access block without cache, RV32, Wishbone classic master
// Region configuration must stay static while accesses are in flight
`default_nettype none

module dmem_ctrl
  import dmem_bus_pkg::*;
  import dmem_pma_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,

  // Region configuration
  input  pma_region_t pma_cfg_i [PMA_CNT],

  // CPU side
  input  logic        mem_req_i,
  input  mem_size_e   mem_size_i,
  input  xword_t      mem_adr_i,
  input  logic        mem_we_i,
  input  xword_t      mem_d_i,
  output logic        mem_rdy_o,
  output xword_t      mem_q_o,
  output logic        mem_ack_o,
  output logic        mem_err_o,
  output logic        mem_misaligned_o,

  // Wishbone master
  output logic        wb_cyc_o,
  output logic        wb_stb_o,
  output logic        wb_we_o,
  output xword_t      wb_adr_o,
  output wb_sel_t     wb_sel_o,
  output xword_t      wb_dat_o,
  input  xword_t      wb_dat_i,
  input  logic        wb_ack_i,
  input  logic        wb_err_i
);

  ////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////

  mem_req_t cpu_req;
  mem_req_t head;
  logic     head_vld;
  pma_hit_t hits [PMA_CNT];
  logic     go;
  logic     deny;
  logic     misaligned;
  logic     pop;

  // CPU request into queue format
  assign cpu_req = '{adr: mem_adr_i, size: mem_size_i, we: mem_we_i, d: mem_d_i};

  // Request queue
  dmem_membuf membuf_inst (
    .clk_i      ( clk_i     ),
    .rst_n_i    ( rst_n_i   ),
    .push_i     ( mem_req_i ),
    .req_i      ( cpu_req   ),
    .pop_i      ( pop       ),
    .head_o     ( head      ),
    .head_vld_o ( head_vld  ),
    .rdy_o      ( mem_rdy_o )
  );

  // One checker per attribute region
  for (genvar i = 0; i < PMA_CNT; i++)
  begin : gen_region
    dmem_pma_region region_inst (
      .cfg_i  ( pma_cfg_i[i] ),
      .head_i ( head         ),
      .hit_o  ( hits[i]      )
    );
  end

  // Priority and alignment
  dmem_pma_resolve resolve_inst (
    .head_i       ( head       ),
    .head_vld_i   ( head_vld   ),
    .hits_i       ( hits       ),
    .go_o         ( go         ),
    .deny_o       ( deny       ),
    .misaligned_o ( misaligned )
  );

  // Bus master and CPU response
  dmem_wb_ctrl wb_ctrl_inst (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .head_i           ( head             ),
    .go_i             ( go               ),
    .deny_i           ( deny             ),
    .misaligned_i     ( misaligned       ),
    .pop_o            ( pop              ),
    .mem_ack_o        ( mem_ack_o        ),
    .mem_err_o        ( mem_err_o        ),
    .mem_misaligned_o ( mem_misaligned_o ),
    .mem_q_o          ( mem_q_o          ),
    .wb_cyc_o         ( wb_cyc_o         ),
    .wb_stb_o         ( wb_stb_o         ),
    .wb_we_o          ( wb_we_o          ),
    .wb_adr_o         ( wb_adr_o         ),
    .wb_sel_o         ( wb_sel_o         ),
    .wb_dat_o         ( wb_dat_o         ),
    .wb_dat_i         ( wb_dat_i         ),
    .wb_ack_i         ( wb_ack_i         ),
    .wb_err_i         ( wb_err_i         )
  );

endmodule : dmem_ctrl

`default_nettype wire

/* dv/dmem_ctrl_checker.sv */
// Scoreboard for dmem_ctrl, samples every port on the falling clock edge
// Expected outcomes are queued when a request is issued, answers must come in order
`default_nettype none

module dmem_ctrl_checker
  import dmem_bus_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,

  // Request and its expected outcome
  input  logic    mem_req_i,
  input  logic    mem_we_i,
  input  xword_t  mem_adr_i,
  input  xword_t  mem_d_i,
  input  int      exp_row_i,
  input  logic    exp_bus_i,
  input  logic    exp_err_i,
  input  logic    exp_mis_i,
  input  wb_sel_t exp_sel_i,
  input  xword_t  exp_q_i,

  // DUT outputs
  input  logic    mem_rdy_i,
  input  logic    mem_ack_i,
  input  logic    mem_err_i,
  input  logic    mem_mis_i,
  input  xword_t  mem_q_i,
  input  logic    wb_cyc_i,
  input  logic    wb_stb_i,
  input  logic    wb_we_i,
  input  xword_t  wb_adr_i,
  input  wb_sel_t wb_sel_i,
  input  xword_t  wb_dat_i,

  // Totals for the closing line
  output int      resp_cnt_o,
  output int      fail_cnt_o,
  output int      err_cnt_o
);

  // One outstanding access
  typedef struct packed {
    logic [15:0] row;
    logic        we;
    xword_t      adr;
    xword_t      d;
    wb_sel_t     sel;
    xword_t      q;
    logic        bus;
    logic        err;
    logic        mis;
  } pend_t;

  pend_t pend_q [$];
  pend_t cur;
  logic  bus_seen = 1'b0;
  logic  row_bad  = 1'b0;
  logic  rst_done = 1'b0;
  logic  rst_bad  = 1'b0;
  int    rst_cyc  = 0;
  int    resp_cnt = 0;
  int    fail_cnt = 0;
  int    err_cnt  = 0;

  assign resp_cnt_o = resp_cnt;
  assign fail_cnt_o = fail_cnt;
  assign err_cnt_o  = err_cnt;

  ////////////////////////////////////////////////////////////
  // Reporting helpers
  ////////////////////////////////////////////////////////////

  task automatic compare_value(input string name, input xword_t got, input xword_t exp);
    if (got !== exp)
    begin
      $display("FAIL row %0d %s got 0x%h exp 0x%h", cur.row, name, got, exp);
      err_cnt++;
      row_bad = 1'b1;
    end
  endtask

  task automatic flag_error(input string msg);
    $display("ERROR %s", msg);
    err_cnt++;
    row_bad = 1'b1;
  endtask

  // Quiet bus and CPU side, queue ready
  task automatic check_idle();
    if (wb_cyc_i || mem_ack_i || mem_err_i || mem_mis_i || !mem_rdy_i)
    begin
      $display("ERROR reset levels wrong, cyc %b ack %b err %b mis %b rdy %b",
               wb_cyc_i, mem_ack_i, mem_err_i, mem_mis_i, mem_rdy_i);
      err_cnt++;
      rst_bad = 1'b1;
    end
  endtask

  // Byte lanes enabled by a select pattern
  function automatic xword_t lane_mask(input wb_sel_t sel);
    xword_t m;
    for (int k = 0; k < SEL_W; k++)
    begin
      m[8*k +: 8] = {8{sel[k]}};
    end
    return m;
  endfunction

  ////////////////////////////////////////////////////////////
  // Per-cycle checks
  ////////////////////////////////////////////////////////////

  task automatic take_request();
    pend_t ent;
    if (mem_req_i)
    begin
      if (!mem_rdy_i)
      begin
        flag_error($sformatf("row %0d issued while mem_rdy_o was low", exp_row_i));
      end
      else
      begin
        ent = '{row: 16'(exp_row_i), we: mem_we_i, adr: mem_adr_i, d: mem_d_i,
                sel: exp_sel_i, q: exp_q_i, bus: exp_bus_i, err: exp_err_i,
                mis: exp_mis_i};
        pend_q.push_back(ent);
      end
    end
  endtask

  // Bus cycle belongs to the oldest unanswered access
  task automatic watch_bus();
    xword_t mask;
    if (wb_cyc_i && !bus_seen)
    begin
      bus_seen = 1'b1;
      if (pend_q.size() == 0)
      begin
        flag_error("bus cycle started with no access outstanding");
      end
      else
      begin
        cur = pend_q[0];
        if (!cur.bus)
        begin
          flag_error($sformatf("row %0d started a bus cycle but must be denied", cur.row));
        end
        compare_value("wb_stb_o", xword_t'(wb_stb_i), 32'h1);
        compare_value("wb_we_o", xword_t'(wb_we_i), xword_t'(cur.we));
        compare_value("wb_adr_o", wb_adr_i, {cur.adr[XLEN-1:2], 2'b00});
        compare_value("wb_sel_o", xword_t'(wb_sel_i), xword_t'(cur.sel));
        // Store data sits on the lanes of its byte offset
        if (cur.we)
        begin
          mask = lane_mask(cur.sel);
          compare_value("wb_dat_o", wb_dat_i & mask,
                        (cur.d << (8 * cur.adr[1:0])) & mask);
        end
      end
    end
  endtask

  task automatic take_response();
    if (mem_ack_i || mem_err_i)
    begin
      if (pend_q.size() == 0)
      begin
        flag_error("response arrived with no access outstanding");
      end
      else
      begin
        cur = pend_q.pop_front();
        compare_value("mem_ack_o", xword_t'(mem_ack_i), xword_t'(!cur.err));
        compare_value("mem_err_o", xword_t'(mem_err_i), xword_t'(cur.err));
        compare_value("mem_misaligned_o", xword_t'(mem_mis_i), xword_t'(cur.mis));
        // Read data only on acknowledged loads
        if (!cur.we && !cur.err)
        begin
          compare_value("mem_q_o", mem_q_i, cur.q);
        end
        if (cur.bus && !bus_seen)
        begin
          flag_error($sformatf("row %0d answered without a bus cycle", cur.row));
        end
        resp_cnt++;
        if (row_bad)
        begin
          fail_cnt++;
          $display("row %0d: mismatch", cur.row);
        end
        else
        begin
          $display("row %0d: ok", cur.row);
        end
      end
      bus_seen = 1'b0;
      row_bad  = 1'b0;
    end
  endtask

  always @(negedge clk_i)
  begin
    if (!rst_n_i)
    begin
      // First cycle still undefined before the synchronous reset lands
      rst_cyc++;
      if (rst_cyc > 1)
      begin
        check_idle();
      end
    end
    else
    begin
      if (!rst_done)
      begin
        check_idle();
        rst_done = 1'b1;
        if (rst_bad)
          $display("reset: idle levels wrong");
        else
          $display("reset: idle levels ok");
      end
      take_response();
      watch_bus();
      take_request();
    end
  end

endmodule : dmem_ctrl_checker

`default_nettype wire

/* dv/dmem_ctrl_tb.sv */
// Testbench for dmem_ctrl, Wishbone slave of 256 words with 0 to 3 wait states
// Slave answers with an error at 0x400 and above, region map is fixed below
`default_nettype none

module dmem_ctrl_tb
  import dmem_bus_pkg::*;
  import dmem_pma_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 16;
  localparam int ROWS       = 23;

  // Expected response kinds
  localparam logic [1:0] K_ACK  = 2'd0;
  localparam logic [1:0] K_BERR = 2'd1;
  localparam logic [1:0] K_DENY = 2'd2;
  localparam logic [1:0] K_MIS  = 2'd3;

  typedef struct packed {
    logic       we;
    mem_size_e  size;
    xword_t     adr;
    xword_t     d;
    logic [1:0] kind;
    wb_sel_t    sel;
    xword_t     q;
  } row_t;

  row_t        rows [ROWS];
  pma_region_t pma_cfg [PMA_CNT];

  logic        clk;
  logic        rst_n;
  logic        mem_req;
  mem_size_e   mem_size;
  xword_t      mem_adr;
  logic        mem_we;
  xword_t      mem_d;
  logic        mem_rdy;
  xword_t      mem_q;
  logic        mem_ack;
  logic        mem_err;
  logic        mem_mis;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  xword_t      wb_adr;
  wb_sel_t     wb_sel;
  xword_t      wb_wdat;
  xword_t      wb_rdat;
  logic        wb_ack;
  logic        wb_err;

  // Expected outcome travelling with each request
  int          exp_row;
  logic        exp_bus;
  logic        exp_err;
  logic        exp_mis;
  wb_sel_t     exp_sel;
  xword_t      exp_q;
  int          resp_cnt;
  int          fail_cnt;
  int          err_cnt;

  // Slave state
  xword_t      slave_mem [256];
  logic [31:0] lcg_state;
  int          wait_left;
  logic        in_cycle;

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  initial
  begin
    rows = '{
      // we    size     adr            wdata          kind    sel      rdata
      '{1'b1, SZ_WORD, 32'h0000_0100, 32'h1122_3344, K_ACK,  4'b1111, 32'h0000_0000},
      '{1'b0, SZ_WORD, 32'h0000_0100, 32'h0000_0000, K_ACK,  4'b1111, 32'h1122_3344},
      '{1'b1, SZ_HALF, 32'h0000_0106, 32'h1234_BEEF, K_ACK,  4'b1100, 32'h0000_0000},
      '{1'b0, SZ_HALF, 32'h0000_0106, 32'h0000_0000, K_ACK,  4'b1100, 32'h0000_BEEF},
      '{1'b0, SZ_WORD, 32'h0000_0104, 32'h0000_0000, K_ACK,  4'b1111, 32'hBEEF_BE41},
      '{1'b1, SZ_BYTE, 32'h0000_010B, 32'hFFFF_FFA5, K_ACK,  4'b1000, 32'h0000_0000},
      '{1'b0, SZ_BYTE, 32'h0000_010B, 32'h0000_0000, K_ACK,  4'b1000, 32'h0000_00A5},
      '{1'b0, SZ_BYTE, 32'h0000_0109, 32'h0000_0000, K_ACK,  4'b0010, 32'h0000_00BD},
      '{1'b0, SZ_HALF, 32'h0000_0108, 32'h0000_0000, K_ACK,  4'b0011, 32'h0000_BD42},
      // Misaligned, never on the bus
      '{1'b1, SZ_HALF, 32'h0000_0101, 32'h0000_AAAA, K_MIS,  4'b0000, 32'h0000_0000},
      '{1'b0, SZ_WORD, 32'h0000_0102, 32'h0000_0000, K_MIS,  4'b0000, 32'h0000_0000},
      '{1'b0, SZ_WORD, 32'h0000_0203, 32'h0000_0000, K_MIS,  4'b0000, 32'h0000_0000},
      // Region 0 is read-only and wins over region 1
      '{1'b1, SZ_WORD, 32'h0000_0080, 32'hDEAD_BEEF, K_DENY, 4'b0000, 32'h0000_0000},
      '{1'b0, SZ_WORD, 32'h0000_0080, 32'h0000_0000, K_ACK,  4'b1111, 32'hD020_DF20},
      // No region, then slave errors
      '{1'b0, SZ_WORD, 32'h0000_0800, 32'h0000_0000, K_DENY, 4'b0000, 32'h0000_0000},
      '{1'b1, SZ_BYTE, 32'h0000_1000, 32'h0000_0055, K_DENY, 4'b0000, 32'h0000_0000},
      '{1'b0, SZ_WORD, 32'h0000_0400, 32'h0000_0000, K_BERR, 4'b1111, 32'h0000_0000},
      '{1'b1, SZ_WORD, 32'h0000_0404, 32'h0102_0304, K_BERR, 4'b1111, 32'h0000_0000},
      '{1'b1, SZ_WORD, 32'h0000_03FC, 32'hCAFE_F00D, K_ACK,  4'b1111, 32'h0000_0000},
      '{1'b0, SZ_WORD, 32'h0000_03FC, 32'h0000_0000, K_ACK,  4'b1111, 32'hCAFE_F00D},
      '{1'b0, SZ_BYTE, 32'h0000_03FD, 32'h0000_0000, K_ACK,  4'b0010, 32'h0000_00F0},
      '{1'b0, SZ_HALF, 32'h0000_03FE, 32'h0000_0000, K_ACK,  4'b1100, 32'h0000_CAFE},
      '{1'b0, SZ_WORD, 32'h0000_0100, 32'h0000_0000, K_ACK,  4'b1111, 32'h1122_3344}
    };
  end

  // Wait states 0 to 3 from an LCG
  function automatic logic [1:0] next_wait();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[17:16];
  endfunction

  task automatic apply_row(input int idx);
    mem_req  = 1'b1;
    mem_we   = rows[idx].we;
    mem_size = rows[idx].size;
    mem_adr  = rows[idx].adr;
    mem_d    = rows[idx].d;
    exp_row  = idx;
    exp_bus  = (rows[idx].kind == K_ACK) || (rows[idx].kind == K_BERR);
    exp_err  = (rows[idx].kind != K_ACK);
    exp_mis  = (rows[idx].kind == K_MIS);
    exp_sel  = rows[idx].sel;
    exp_q    = rows[idx].q;
  endtask

  // Single access on the slave side
  task automatic answer_access();
    if (wb_adr >= 32'h0000_0400)
    begin
      wb_err = 1'b1;
    end
    else
    begin
      if (wb_we)
      begin
        for (int k = 0; k < 4; k++)
        begin
          if (wb_sel[k])
            slave_mem[wb_adr[9:2]][8*k +: 8] = wb_wdat[8*k +: 8];
        end
      end
      else
      begin
        wb_rdat = slave_mem[wb_adr[9:2]];
      end
      wb_ack = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Clock, reset and request stream
  ////////////////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2);
      clk = ~clk;
    end
  end

  initial
  begin
    int idx;
    rst_n    = 1'b0;
    mem_req  = 1'b0;
    mem_we   = 1'b0;
    mem_size = SZ_BYTE;
    mem_adr  = '0;
    mem_d    = '0;
    exp_row  = 0;
    exp_bus  = 1'b0;
    exp_err  = 1'b0;
    exp_mis  = 1'b0;
    exp_sel  = '0;
    exp_q    = '0;
    // Region 0 read-only low page, 1 and 2 read-write, 3 off
    pma_cfg[0] = '{base: 32'h0000_0000, mask: 32'hFFFF_FF00, en: 1'b1, rd: 1'b1, wr: 1'b0};
    pma_cfg[1] = '{base: 32'h0000_0000, mask: 32'hFFFF_FC00, en: 1'b1, rd: 1'b1, wr: 1'b1};
    pma_cfg[2] = '{base: 32'h0000_0400, mask: 32'hFFFF_FC00, en: 1'b1, rd: 1'b1, wr: 1'b1};
    pma_cfg[3] = '{base: 32'h0000_0000, mask: 32'h0000_0000, en: 1'b0, rd: 1'b1, wr: 1'b1};
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    idx   = 0;
    // Back to back, held off only by mem_rdy_o
    while (idx < ROWS)
    begin
      @(posedge clk);
      #1;
      if (mem_rdy)
      begin
        apply_row(idx);
        idx++;
      end
      else
      begin
        mem_req = 1'b0;
      end
    end
    @(posedge clk);
    #1;
    mem_req = 1'b0;
    wait (resp_cnt == ROWS);
    // Room for stray responses
    repeat (8) @(posedge clk);
    $display("rows %0d, responses %0d, failed rows %0d, errors %0d",
             ROWS, resp_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // Slave memory, answers a fixed delay after the edge
  initial
  begin
    wb_ack    = 1'b0;
    wb_err    = 1'b0;
    wb_rdat   = '0;
    in_cycle  = 1'b0;
    wait_left = 0;
    lcg_state = 32'd58415;
    for (int i = 0; i < 256; i++)
      slave_mem[i] = {8'hD0, 8'(i), ~8'(i), 8'(i)};
    forever
    begin
      @(posedge clk);
      #1;
      if (wb_ack || wb_err)
      begin
        wb_ack   = 1'b0;
        wb_err   = 1'b0;
        in_cycle = 1'b0;
      end
      else if (wb_cyc && wb_stb)
      begin
        if (!in_cycle)
        begin
          in_cycle  = 1'b1;
          wait_left = int'(next_wait());
        end
        if (wait_left > 0)
          wait_left--;
        else
          answer_access();
      end
    end
  end

  // Watchdog
  initial
  begin
    #((ROWS * 20 + RST_CYCLES) * CLK_PERIOD);
    $display("timeout with %0d of %0d responses received", resp_cnt, ROWS);
    $display("** FAIL **");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // DUT and checker
  ////////////////////////////////////////////////////////////

  dmem_ctrl u_dmem_ctrl (
    .clk_i            ( clk      ),
    .rst_n_i          ( rst_n    ),
    .pma_cfg_i        ( pma_cfg  ),
    .mem_req_i        ( mem_req  ),
    .mem_size_i       ( mem_size ),
    .mem_adr_i        ( mem_adr  ),
    .mem_we_i         ( mem_we   ),
    .mem_d_i          ( mem_d    ),
    .mem_rdy_o        ( mem_rdy  ),
    .mem_q_o          ( mem_q    ),
    .mem_ack_o        ( mem_ack  ),
    .mem_err_o        ( mem_err  ),
    .mem_misaligned_o ( mem_mis  ),
    .wb_cyc_o         ( wb_cyc   ),
    .wb_stb_o         ( wb_stb   ),
    .wb_we_o          ( wb_we    ),
    .wb_adr_o         ( wb_adr   ),
    .wb_sel_o         ( wb_sel   ),
    .wb_dat_o         ( wb_wdat  ),
    .wb_dat_i         ( wb_rdat  ),
    .wb_ack_i         ( wb_ack   ),
    .wb_err_i         ( wb_err   )
  );

  dmem_ctrl_checker u_checker (
    .clk_i      ( clk      ),
    .rst_n_i    ( rst_n    ),
    .mem_req_i  ( mem_req  ),
    .mem_we_i   ( mem_we   ),
    .mem_adr_i  ( mem_adr  ),
    .mem_d_i    ( mem_d    ),
    .exp_row_i  ( exp_row  ),
    .exp_bus_i  ( exp_bus  ),
    .exp_err_i  ( exp_err  ),
    .exp_mis_i  ( exp_mis  ),
    .exp_sel_i  ( exp_sel  ),
    .exp_q_i    ( exp_q    ),
    .mem_rdy_i  ( mem_rdy  ),
    .mem_ack_i  ( mem_ack  ),
    .mem_err_i  ( mem_err  ),
    .mem_mis_i  ( mem_mis  ),
    .mem_q_i    ( mem_q    ),
    .wb_cyc_i   ( wb_cyc   ),
    .wb_stb_i   ( wb_stb   ),
    .wb_we_i    ( wb_we    ),
    .wb_adr_i   ( wb_adr   ),
    .wb_sel_i   ( wb_sel   ),
    .wb_dat_i   ( wb_wdat  ),
    .resp_cnt_o ( resp_cnt ),
    .fail_cnt_o ( fail_cnt ),
    .err_cnt_o  ( err_cnt  )
  );

endmodule : dmem_ctrl_tb

`default_nettype wire

/* project.f */
src/dmem_bus_pkg.sv
src/dmem_pma_pkg.sv
src/dmem_membuf.sv
src/dmem_pma_region.sv
src/dmem_pma_resolve.sv
src/dmem_wb_ctrl.sv
src/dmem_ctrl.sv
dv/dmem_ctrl_checker.sv
dv/dmem_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run dmem_ctrl_tb with Verilator, result taken from sim.log
verilator --binary --timing -Wno-fatal --top-module dmem_ctrl_tb -f project.f \
  -o dmem_ctrl_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/dmem_ctrl_sim > sim.log 2>&1
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation failed"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"
